// File: logic/cfg_pkg.sv
//////////////////////////////////////////////////////////////////////
// config word format shared by decoder and register bank
// bit 15 picks the view: 0 = register write, 1 = command
//////////////////////////////////////////////////////////////////////

package cfg_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and sizes
  //////////////////////////////////////////////////////////////////////
  localparam int CFG_WORD_W   = 16; // one config word on the stream
  localparam int CFG_VALUE_W  = 12; // payload of a register write
  localparam int CFG_ADDR_W   = 3;  // register index
  localparam int CFG_OP_W     = 3;  // command opcode field
  localparam int CFG_NUM_REGS = 8;  // shadow/active pairs in the bank

  //////////////////////////////////////////////////////////////////////
  // command opcodes, 3..7 are illegal
  //////////////////////////////////////////////////////////////////////
  localparam logic [CFG_OP_W-1:0] OP_NOP    = 3'd0; // does nothing
  localparam logic [CFG_OP_W-1:0] OP_COMMIT = 3'd1; // shadows -> active
  localparam logic [CFG_OP_W-1:0] OP_CLEAR  = 3'd2; // zero the shadows

  // register write view
  typedef struct packed {
    logic                   kind;  // 0 for a write
    logic [CFG_ADDR_W-1:0]  addr;  // shadow register to update
    logic [CFG_VALUE_W-1:0] value; // new shadow value
  } write_t;

  // command view
  typedef struct packed {
    logic                   kind;   // 1 for a command
    logic [CFG_OP_W-1:0]    opcode; // see OP_* above
    logic [CFG_VALUE_W-1:0] arg;    // reserved, ignored by the bank
  } cmd_t;

  // same 16 bits, read one way or the other by the kind bit
  typedef union packed {
    write_t wr;
    cmd_t   cmd;
  } cfg_word_t;

endpackage : cfg_pkg

// File: logic/cdc_pkg.sv
//////////////////////////////////////////////////////////////////////
// handshake crossing constants, one packet in flight at a time
//////////////////////////////////////////////////////////////////////

package cdc_pkg;
  import cfg_pkg::*;

  // flops per synchronizer chain, req and ack alike
  // 4 stages keeps MTBF comfortable at the expected clock rates
  localparam int CDC_SYNC_STAGES = 4;

  // crossing packet = config word plus last flag on top
  localparam int CDC_PACKET_W = CFG_WORD_W + 1;

endpackage : cdc_pkg

// File: logic/cfg_handshake_cdc.sv
//////////////////////////////////////////////////////////////////////
// four-phase req/ack crossing from src_clk into dest_clk
// one word in flight at a time
// src_ready stays low until ack has come and gone
//////////////////////////////////////////////////////////////////////

module cfg_handshake_cdc import cfg_pkg::*, cdc_pkg::*; (
  // source side
  input  logic                  src_clk,
  input  logic                  src_reset,
  input  logic                  src_valid,
  output logic                  src_ready,
  input  logic [CFG_WORD_W-1:0] src_word,
  input  logic                  src_last,

  // destination side
  input  logic                  dest_clk,
  input  logic                  dest_reset,
  output logic                  xw_valid,
  input  logic                  xw_ready,
  output logic [CFG_WORD_W-1:0] xw_word,
  output logic                  xw_last
);

  //////////////////////////////////////////////////////////////////////
  // source clock domain
  //////////////////////////////////////////////////////////////////////
  logic                       src_send;   // req toward dest held until rcv
  logic                       src_rcv;    // ack seen back in src_clk
  logic [CDC_PACKET_W-1:0]    src_packet; // {last, word} frozen while send
  logic [CDC_SYNC_STAGES-1:0] ack_sync;   // dest_ack -> src_clk chain
  logic                       src_xfer;
  logic                       dest_ack;   // dest_clk flop back toward src via ack_sync

  assign src_rcv   = ack_sync[CDC_SYNC_STAGES-1];
  // idle only once both phases of the previous handshake are finished
  assign src_ready = ~(src_send | src_rcv);
  assign src_xfer  = src_valid & src_ready;

  always_ff @(posedge src_clk) begin
    if (src_xfer) begin
      src_packet <= {src_last, src_word}; // capture only on transfer
    end
    if (src_reset) begin
      src_send <= 1'b0;
      ack_sync <= '0;
    end else begin
      ack_sync <= {ack_sync[CDC_SYNC_STAGES-2:0], dest_ack};
      if (src_xfer) begin
        src_send <= 1'b1;
      end else if (src_send & src_rcv) begin
        src_send <= 1'b0; // dest has the word so req drops
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // destination clock domain
  //////////////////////////////////////////////////////////////////////
  logic [CDC_SYNC_STAGES-1:0] req_sync;  // src_send -> dest_clk chain
  logic                       dest_req;
  logic                       xfer_done; // word handed on and waiting for req low
  logic                       xw_xfer;

  assign dest_req = req_sync[CDC_SYNC_STAGES-1];
  assign xw_xfer  = xw_valid & xw_ready;

  // packet is sampled straight from src_packet; by the time req has
  // walked the chain it has been stable for several src cycles
  always_ff @(posedge dest_clk) begin
    if (~xfer_done & dest_req & ~xw_valid) begin
      {xw_last, xw_word} <= src_packet;
    end
    if (dest_reset) begin
      req_sync  <= '0;
      xw_valid  <= 1'b0;
      dest_ack  <= 1'b0;
      xfer_done <= 1'b0;
    end else begin
      req_sync <= {req_sync[CDC_SYNC_STAGES-2:0], src_send};
      if (xw_xfer) begin
        xw_valid  <= 1'b0; // word taken downstream
        dest_ack  <= 1'b1; // tell src it can let go
        xfer_done <= 1'b1;
      end else if (~xfer_done & dest_req) begin
        xw_valid <= 1'b1;
      end else if (dest_ack & ~dest_req) begin
        // req dropped so the handshake closes out
        dest_ack  <= 1'b0;
        xfer_done <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // dest samples src_packet asynchronously and it must not move while req is up
  a_src_packet_stable : assert property (
    @(posedge src_clk) disable iff (src_reset)
    src_send |=> $stable(src_packet)
  ) else $error("src packet changed during a crossing");

endmodule : cfg_handshake_cdc

// File: logic/cfg_word_decoder.sv
//////////////////////////////////////////////////////////////////////
// single-register decode stage, write or command per the kind bit
// illegal opcodes are dropped here, their last flag goes with them
//////////////////////////////////////////////////////////////////////

module cfg_word_decoder import cfg_pkg::*; (
  input  logic                   dest_clk,
  input  logic                   dest_reset,

  // from the crossing
  input  logic                   xw_valid,
  output logic                   xw_ready,
  input  logic [CFG_WORD_W-1:0]  xw_word,
  input  logic                   xw_last,

  // to the register bank
  output logic                   dw_valid,
  input  logic                   dw_ready,
  output logic                   dw_is_cmd,
  output logic [CFG_ADDR_W-1:0]  dw_addr,
  output logic [CFG_OP_W-1:0]    dw_opcode,
  output logic [CFG_VALUE_W-1:0] dw_value,
  output logic                   dw_last,
  output logic                   illegal   // one cycle per dropped word
);

  cfg_word_t word_in;  // xw_word seen through both views
  logic      is_cmd;
  logic      op_legal;
  logic      accept;

  assign word_in  = xw_word;
  assign is_cmd   = word_in.cmd.kind; // kind sits in the same bit for both views
  // writes are always legal, commands only up to OP_CLEAR
  assign op_legal = ~is_cmd | (word_in.cmd.opcode <= OP_CLEAR);

  // empty, or the held word leaves this cycle
  assign xw_ready = ~dw_valid | dw_ready;
  assign accept   = xw_valid & xw_ready;

  always_ff @(posedge dest_clk) begin
    if (accept) begin
      dw_is_cmd <= is_cmd;
      dw_addr   <= word_in.wr.addr;     // meaningful for writes only
      dw_opcode <= word_in.cmd.opcode;  // meaningful for commands only
      dw_value  <= word_in.wr.value;    // cmd arg lands here too, bank ignores it
      dw_last   <= xw_last;
    end
    if (dest_reset) begin
      dw_valid <= 1'b0;
      illegal  <= 1'b0;
    end else begin
      if (accept) begin
        dw_valid <= op_legal; // illegal word is swallowed, stage stays empty
      end else if (dw_ready) begin
        dw_valid <= 1'b0;
      end
      illegal <= accept & ~op_legal;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // the bank has no illegal branch, only NOP/COMMIT/CLEAR may reach it
  a_no_illegal_out : assert property (
    @(posedge dest_clk) disable iff (dest_reset)
    dw_valid && dw_is_cmd |-> dw_opcode <= OP_CLEAR
  ) else $error("illegal opcode presented to register bank");

endmodule : cfg_word_decoder

// File: logic/cfg_register_bank.sv
//////////////////////////////////////////////////////////////////////
// shadow + active config registers with active changing only on commit
// freeze stalls the whole channel back to src_ready
//////////////////////////////////////////////////////////////////////

module cfg_register_bank import cfg_pkg::*; (
  input  logic                                     dest_clk,
  input  logic                                     dest_reset,

  // decoded words
  input  logic                                     dw_valid,
  output logic                                     dw_ready,
  input  logic                                     dw_is_cmd,
  input  logic [CFG_ADDR_W-1:0]                    dw_addr,
  input  logic [CFG_OP_W-1:0]                      dw_opcode,
  input  logic [CFG_VALUE_W-1:0]                   dw_value,
  input  logic                                     dw_last,
  input  logic                                     illegal,

  input  logic                                     freeze,     // hold off new words
  output logic [CFG_NUM_REGS-1:0][CFG_VALUE_W-1:0] cfg_values, // active set
  output logic                                     batch_done, // 1 cycle after a last word
  output logic                                     cfg_error   // sticky until reset
);

  logic [CFG_NUM_REGS-1:0][CFG_VALUE_W-1:0] shadow; // staged values
  logic                                     accept;

  assign dw_ready = ~freeze;
  assign accept   = dw_valid & dw_ready;

  //////////////////////////////////////////////////////////////////////
  // register update
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge dest_clk) begin
    if (dest_reset) begin
      shadow     <= '0;
      cfg_values <= '0;
      batch_done <= 1'b0;
      cfg_error  <= 1'b0;
    end else begin
      batch_done <= accept & dw_last;
      if (illegal) begin
        cfg_error <= 1'b1; // stays up until reset
      end
      if (accept) begin
        if (!dw_is_cmd) begin
          shadow[dw_addr] <= dw_value;
        end else begin
          case (dw_opcode)
            OP_NOP:    ;                     // nothing to do
            OP_COMMIT: cfg_values <= shadow; // all eight at once
            OP_CLEAR:  shadow <= '0;         // active set untouched
            default:   ;                     // filtered by decoder
          endcase
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // a stalled word must hold still until the bank takes it
  a_dw_stable : assert property (
    @(posedge dest_clk) disable iff (dest_reset)
    dw_valid && !dw_ready |=>
      dw_valid && $stable({dw_is_cmd, dw_addr, dw_opcode, dw_value, dw_last})
  ) else $error("decoded word changed while stalled by freeze");

endmodule : cfg_register_bank

// File: logic/cfg_channel_top.sv
//////////////////////////////////////////////////////////////////////
// config channel: src stream -> crossing -> decoder -> register bank
//////////////////////////////////////////////////////////////////////

module cfg_channel_top import cfg_pkg::*; (
  // source domain stream
  input  logic                                     src_clk,
  input  logic                                     src_reset,
  input  logic                                     src_valid,
  output logic                                     src_ready,
  input  logic [CFG_WORD_W-1:0]                    src_word,
  input  logic                                     src_last,

  // destination domain
  input  logic                                     dest_clk,
  input  logic                                     dest_reset,
  input  logic                                     freeze,
  output logic [CFG_NUM_REGS-1:0][CFG_VALUE_W-1:0] cfg_values,
  output logic                                     batch_done,
  output logic                                     cfg_error
);

  // crossing -> decoder
  logic                   xw_valid;
  logic                   xw_ready;
  logic [CFG_WORD_W-1:0]  xw_word;
  logic                   xw_last;

  // decoder -> bank
  logic                   dw_valid;
  logic                   dw_ready;
  logic                   dw_is_cmd;
  logic [CFG_ADDR_W-1:0]  dw_addr;
  logic [CFG_OP_W-1:0]    dw_opcode;
  logic [CFG_VALUE_W-1:0] dw_value;
  logic                   dw_last;
  logic                   illegal;

  cfg_handshake_cdc i_cfg_handshake_cdc (
    .src_clk, .src_reset, .src_valid, .src_ready, .src_word, .src_last,
    .dest_clk, .dest_reset, .xw_valid, .xw_ready, .xw_word, .xw_last
  );

  cfg_word_decoder i_cfg_word_decoder (
    .dest_clk, .dest_reset, .xw_valid, .xw_ready, .xw_word, .xw_last,
    .dw_valid, .dw_ready, .dw_is_cmd, .dw_addr, .dw_opcode, .dw_value, .dw_last,
    .illegal
  );

  cfg_register_bank i_cfg_register_bank (
    .dest_clk, .dest_reset,
    .dw_valid, .dw_ready, .dw_is_cmd, .dw_addr, .dw_opcode, .dw_value, .dw_last,
    .illegal, .freeze, .cfg_values, .batch_done, .cfg_error
  );

endmodule : cfg_channel_top

// File: tests/cfg_channel_tb.sv
//////////////////////////////////////////////////////////////////////
// src_clk 28 ns against dest_clk 40 ns, words from xorshift seed 42513
// model follows the sent words only, checks are concurrent assertions
//////////////////////////////////////////////////////////////////////

module cfg_channel_tb import cfg_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          DEST_HALF     = 20;
  localparam int          SRC_HALF      = 14;
  localparam int          RESET_CYCLES  = 10;
  localparam logic [31:0] SEED          = 32'd42513;
  localparam int          WORD_TIMEOUT  = 400;  // src cycles until a word is taken
  localparam int          BATCH_TIMEOUT = 4000; // dest cycles until batch_done catches up

  // DUT ports
  logic                                     src_clk = 1'b0;
  logic                                     dest_clk = 1'b0;
  logic                                     src_reset;
  logic                                     dest_reset;
  logic                                     src_valid;
  logic                                     src_ready;
  logic [CFG_WORD_W-1:0]                    src_word;
  logic                                     src_last;
  logic                                     freeze;
  logic [CFG_NUM_REGS-1:0][CFG_VALUE_W-1:0] cfg_values;
  logic                                     batch_done;
  logic                                     cfg_error;

  // reference model and bookkeeping
  logic [CFG_NUM_REGS-1:0][CFG_VALUE_W-1:0] model_shadow;
  logic [CFG_NUM_REGS-1:0][CFG_VALUE_W-1:0] model_active;
  logic                                     model_error;
  int                                       last_sent;   // legal words sent with last
  int                                       batch_count; // batch_done cycles seen
  int                                       error_count;
  int                                       check_count;
  logic                                     check_en;    // one-cycle strobe for value checks
  logic                                     final_en;    // pulse count check at the end
  logic                                     hold_en;     // no commit in flight, values frozen
  logic                                     freeze_en;
  logic [31:0]                              word_rng;
  logic [31:0]                              freeze_rng;
  string                                    test_name;

  always #DEST_HALF dest_clk = ~dest_clk;
  always #SRC_HALF  src_clk  = ~src_clk;

  cfg_channel_top i_cfg_channel_top (
    .src_clk, .src_reset, .src_valid, .src_ready, .src_word, .src_last,
    .dest_clk, .dest_reset, .freeze, .cfg_values, .batch_done, .cfg_error
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // bit 15 kind, then 3-bit address or opcode, then 12-bit payload
  function automatic logic [CFG_WORD_W-1:0] write_word(input logic [2:0] addr,
                                                        input logic [11:0] value);
    return {1'b0, addr, value};
  endfunction

  function automatic logic [CFG_WORD_W-1:0] cmd_word(input logic [2:0] op,
                                                      input logic [11:0] arg);
    return {1'b1, op, arg}; // arg should be ignored by the bank
  endfunction

  //////////////////////////////////////////////////////////////////////
  // dest-side helpers
  //////////////////////////////////////////////////////////////////////
  always @(posedge dest_clk) begin
    if (dest_reset) begin
      batch_count <= 0;
    end else if (batch_done) begin
      batch_count <= batch_count + 1;
    end
  end

  always @(posedge dest_clk) begin
    if (freeze_en) begin
      freeze_rng = xorshift32(freeze_rng);
      freeze <= (freeze_rng[3:0] < 4'd6); // frozen roughly 40% of cycles
    end else begin
      freeze <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////
  a_values : assert property (@(posedge dest_clk) disable iff (dest_reset)
    check_en |-> cfg_values == model_active)
  else begin
    error_count++;
    $display("CHECK FAILED %s: cfg_values expected %h actual %h",
             test_name, $sampled(model_active), $sampled(cfg_values));
  end

  a_error_flag : assert property (@(posedge dest_clk) disable iff (dest_reset)
    check_en |-> cfg_error == model_error)
  else begin
    error_count++;
    $display("CHECK FAILED %s: cfg_error expected %b actual %b",
             test_name, $sampled(model_error), $sampled(cfg_error));
  end

  a_error_sticky : assert property (@(posedge dest_clk) disable iff (dest_reset)
    cfg_error |=> cfg_error)
  else begin
    error_count++;
    $display("CHECK FAILED %s: cfg_error expected 1 actual 0", test_name);
  end

  // writes and nops alone must never reach the active set
  a_values_held : assert property (@(posedge dest_clk) disable iff (dest_reset)
    hold_en |-> $stable(cfg_values))
  else begin
    error_count++;
    $display("CHECK FAILED %s: cfg_values expected %h actual %h",
             test_name, $past(cfg_values), $sampled(cfg_values));
  end

  a_pulse_count : assert property (@(posedge dest_clk) disable iff (dest_reset)
    final_en |-> batch_count == last_sent)
  else begin
    error_count++;
    $display("CHECK FAILED %s: batch_done pulses expected %0d actual %0d",
             test_name, last_sent, batch_count);
  end

  a_pulse_width : assert property (@(posedge dest_clk) disable iff (dest_reset)
    batch_done |=> !batch_done) // one word crosses at a time
  else begin
    error_count++;
    $display("CHECK FAILED %s: batch_done expected 0 actual 1", test_name);
  end

  a_src_busy : assert property (@(posedge src_clk) disable iff (src_reset)
    src_valid && src_ready |=> !src_ready)
  else begin
    error_count++;
    $display("CHECK FAILED %s: src_ready expected 0 actual 1", test_name);
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////////////////////////
  task automatic abort_run(input string what);
    $display("timeout: %s", what);
    $display("checks run: %0d, errors: %0d", check_count, error_count);
    $display("Checks failed");
    $finish;
  endtask

  // applies the word's rule to the model once it has been taken
  task automatic apply_model(input logic [CFG_WORD_W-1:0] word, input logic last);
    if (!word[15]) begin
      model_shadow[word[14:12]] = word[11:0];
    end else if (word[14:12] == OP_COMMIT) begin
      model_active = model_shadow;
    end else if (word[14:12] == OP_CLEAR) begin
      model_shadow = '0;
    end else if (word[14:12] != OP_NOP) begin
      model_error = 1'b1; // dropped, its last goes too
      return;
    end
    if (last) begin
      last_sent++;
    end
  endtask

  task automatic send_word(input logic [CFG_WORD_W-1:0] word, input logic last);
    int waited;
    @(posedge src_clk);
    src_valid <= 1'b1;
    src_word  <= word;
    src_last  <= last;
    waited = 0;
    @(negedge src_clk); // ready is settled mid-cycle
    while (!src_ready && waited < WORD_TIMEOUT) begin
      @(negedge src_clk);
      waited++;
    end
    if (!src_ready) begin
      abort_run("src_ready never came back, the word was not taken");
    end
    @(posedge src_clk); // transfer edge
    src_valid <= 1'b0;
    apply_model(word, last);
  endtask

  task automatic send_random(input logic allow_cmd, input logic allow_last);
    logic [2:0] op;
    logic       last;
    word_rng = xorshift32(word_rng);
    last = allow_last & (word_rng[21:20] == 2'd0); // about 1 in 4
    op = (word_rng[17:16] == 2'd2) ? OP_CLEAR : (word_rng[16] ? OP_COMMIT : OP_NOP);
    if (allow_cmd && word_rng[31:29] == 3'd0) begin
      send_word(cmd_word(op, word_rng[11:0]), last);
    end else begin
      send_word(write_word(word_rng[14:12], word_rng[11:0]), last);
    end
  endtask

  // returns once batch_done has caught up with every last word sent
  task automatic wait_batches();
    int waited;
    waited = 0;
    @(posedge dest_clk);
    while (batch_count < last_sent && waited < BATCH_TIMEOUT) begin
      @(posedge dest_clk);
      waited++;
    end
    if (batch_count < last_sent) begin
      abort_run("batch_done did not arrive for every last word");
    end
  endtask

  task automatic run_check(input logic count_pulses);
    @(posedge dest_clk);
    check_en <= 1'b1;
    final_en <= count_pulses;
    @(posedge dest_clk);
    check_en <= 1'b0;
    final_en <= 1'b0;
    check_count++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    src_reset    = 1'b1;
    dest_reset   = 1'b1;
    src_valid    = 1'b0;
    src_word     = '0;
    src_last     = 1'b0;
    freeze       = 1'b0;
    model_shadow = '0;
    model_active = '0;
    model_error  = 1'b0;
    last_sent    = 0;
    error_count  = 0;
    check_count  = 0;
    check_en     = 1'b0;
    final_en     = 1'b0;
    hold_en      = 1'b0;
    freeze_en    = 1'b0;
    word_rng     = SEED;
    freeze_rng   = ~SEED; // separate stream for freeze
    test_name    = "after_reset";

    fork
      begin
        repeat (RESET_CYCLES) @(posedge src_clk);
        src_reset <= 1'b0;
      end
      begin
        repeat (RESET_CYCLES) @(posedge dest_clk);
        dest_reset <= 1'b0;
      end
    join
    repeat (4) @(posedge dest_clk);
    run_check(1'b0);

    // every register written, then one commit
    test_name = "commit";
    for (int i = 0; i < CFG_NUM_REGS; i++) begin
      word_rng = xorshift32(word_rng);
      send_word(write_word(3'(i), word_rng[11:0]), 1'b0);
    end
    repeat (4) send_random(1'b0, 1'b0);
    send_word(cmd_word(OP_COMMIT, 12'h000), 1'b1);
    wait_batches();
    run_check(1'b0);

    test_name = "no_commit";
    hold_en <= 1'b1;
    repeat (6) send_random(1'b0, 1'b0);
    send_word(write_word(3'd5, 12'habc), 1'b1);
    wait_batches();
    run_check(1'b0);
    hold_en <= 1'b0;

    test_name = "clear_commit";
    send_word(cmd_word(OP_CLEAR, 12'hfff), 1'b0);
    send_word(cmd_word(OP_COMMIT, 12'h000), 1'b1);
    wait_batches();
    run_check(1'b0);

    test_name = "freeze_random";
    freeze_en <= 1'b1;
    repeat (48) send_random(1'b1, 1'b1);
    send_word(cmd_word(OP_COMMIT, 12'h000), 1'b1);
    wait_batches();
    freeze_en <= 1'b0;
    run_check(1'b0);

    // illegal opcode between writes, closed by a nop so batch_done shows up
    test_name = "illegal_opcode";
    hold_en <= 1'b1;
    send_random(1'b0, 1'b0);
    word_rng = xorshift32(word_rng);
    send_word(cmd_word(3'd3 + 3'(word_rng[3:0] % 5), word_rng[15:4]), 1'b0);
    send_random(1'b0, 1'b0);
    send_word(cmd_word(OP_NOP, 12'h000), 1'b1);
    wait_batches();
    run_check(1'b0);
    hold_en <= 1'b0;

    test_name = "error_sticky";
    send_word(write_word(3'd2, 12'h5a5), 1'b0);
    send_word(cmd_word(OP_COMMIT, 12'h000), 1'b1);
    wait_batches();
    run_check(1'b1);

    repeat (4) @(posedge dest_clk);
    $display("checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule : cfg_channel_tb

// File: all.f
logic/cfg_pkg.sv
logic/cdc_pkg.sv
logic/cfg_handshake_cdc.sv
logic/cfg_word_decoder.sv
logic/cfg_register_bank.sv
logic/cfg_channel_top.sv
tests/cfg_channel_tb.sv

// File: Makefile
# Verilator build and run for the config channel testbench

VERILATOR ?= verilator
TOP       ?= cfg_channel_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD_DIR)/$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx 'All checks passed' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
